/* source/rv_decode_defines.svh */
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// Instruction and data width
`define RV_XLEN 32

// Default register placement in the decoder
// 1 stores the raw instruction fields, 0 stores the decoded groups
`define RV_DEC_PRE_REGISTER 1

// Lowest nonzero bit of a U-type immediate
`define RV_IMM_U_LSB 12

`endif

/* source/rv_decode_pkg.sv */
`include "rv_decode_defines.svh"

package rv_decode_pkg;

   // Instruction word without bits 1:0, which are always 2'b11
   typedef logic [`RV_XLEN-1:2] instr_t;

   // Major opcode, instruction bits 6:2
   typedef logic [4:0] opcode_t;

   typedef logic [2:0] funct3_t;

   // Address of the CSRs kept outside the CSR block
   typedef logic [1:0] csr_addr_t;

   // Immediate decoder format select and group shift enables
   typedef logic [3:0] immdec_t;

   typedef struct packed {
      logic    sh_right;
      logic    bne_or_bge;
      logic    cond_branch;
      logic    e_op;
      logic    ebreak;
      logic    branch_op;
      logic    mem_op;
      logic    shift_op;
      logic    slt_op;
      logic    rd_op;
      logic    mdu_op;
      funct3_t mdu_opcode;
   } dec_state_t;

   typedef struct packed {
      logic rs1_en;
      logic imm_en;
      logic clr_lsb;
      logic sh_signed;
   } dec_bufreg_t;

   typedef struct packed {
      logic jal_or_jalr;
      logic utype;
      logic pc_rel;
      logic mret;
   } dec_ctrl_t;

   // rd_sel is one-hot, bit 0 add, bit 1 slt, bit 2 bool
   typedef struct packed {
      logic       sub;
      logic [1:0] bool_op;
      logic       cmp_eq;
      logic       cmp_sig;
      logic [2:0] rd_sel;
   } dec_alu_t;

   // is_signed selects sign extension of loaded data
   typedef struct packed {
      logic is_signed;
      logic word;
      logic half;
      logic cmd;
   } dec_mem_t;

   typedef struct packed {
      logic       en;
      csr_addr_t  addr;
      logic       mstatus_en;
      logic       mie_en;
      logic       mcause_en;
      logic [1:0] source;
      logic       d_sel;
      logic       imm_en;
   } dec_csr_t;

   typedef struct packed {
      immdec_t immdec_ctrl;
      immdec_t immdec_en;
      logic    op_b_source;
      logic    rd_csr_en;
      logic    rd_alu_en;
   } dec_misc_t;

endpackage

/* source/rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module rv_decoder
   import rv_decode_pkg::*;
#(
   parameter bit PRE_REGISTER = `RV_DEC_PRE_REGISTER
) (
   input  logic        clk,
   input  logic        i_arst_n,
   input  logic        i_wb_en,
   input  instr_t      i_wb_rdt,
   output dec_state_t  o_state,
   output dec_bufreg_t o_bufreg,
   output dec_ctrl_t   o_ctrl,
   output dec_alu_t    o_alu,
   output dec_mem_t    o_mem,
   output dec_csr_t    o_csr,
   output dec_misc_t   o_misc
);

   localparam opcode_t OPC_OP = 5'b01100;

   // Instruction bits that the decode depends on
   typedef struct packed {
      opcode_t opcode;
      funct3_t funct3;
      logic    op20;
      logic    op21;
      logic    op22;
      logic    op26;
      logic    imm25;
      logic    imm30;
   } fields_t;

   typedef struct packed {
      dec_state_t  state;
      dec_bufreg_t bufreg;
      dec_ctrl_t   ctrl;
      dec_alu_t    alu;
      dec_mem_t    mem;
      dec_csr_t    csr;
      dec_misc_t   misc;
   } dec_groups_t;

   function automatic dec_groups_t decode(input fields_t f);
      logic        sys;
      logic        op_or_opimm;
      logic        csr_op;
      logic        csr_valid;
      logic        f3_zero;
      opcode_t     op;
      dec_groups_t d;

      op          = f.opcode;
      sys         = op[4] & op[2];
      op_or_opimm = !op[4] & op[2] & !op[0];
      f3_zero     = (f.funct3 == 3'b000);
      // CSR accesses only, funct3 zero is mret, ecall or ebreak
      csr_op      = sys & !f3_zero;
      // Externally stored CSRs: mtvec, mscratch, mepc, mtval
      csr_valid   = f.op20 | (f.op26 & !f.op21);

      // Execution state
      d.state.sh_right    = f.funct3[2];
      d.state.bne_or_bge  = f.funct3[0];
      d.state.cond_branch = !op[0];
      d.state.e_op        = sys & !f.op21 & f3_zero;
      d.state.ebreak      = f.op20;
      d.state.branch_op   = op[4] & !op[2];
      d.state.mem_op      = !op[4] & !op[2] & !op[0];
      d.state.shift_op    = op_or_opimm & (f.funct3[1:0] == 2'b01);
      d.state.slt_op      = op_or_opimm & (f.funct3[2:1] == 2'b01);
      // No rd write for STORE and BRANCH
      d.state.rd_op       = op[2] | (op[4] & op[0]) | (!op[3] & !op[0]);
      d.state.mdu_op      = (op == OPC_OP) & f.imm25;
      d.state.mdu_opcode  = f.funct3;

      // Buffer register, rs1 for JALR, memory and shifts
      d.bufreg.rs1_en    = !op[4] | (!op[1] & op[0]);
      d.bufreg.imm_en    = !op[2];
      d.bufreg.clr_lsb   = op[4] & ((op[1:0] == 2'b00) | (op[1:0] == 2'b11));
      d.bufreg.sh_signed = f.imm30;

      // Program counter
      d.ctrl.jal_or_jalr = op[4] & op[0];
      d.ctrl.utype       = !op[4] & op[2] & op[0];
      d.ctrl.pc_rel      = (op[2:0] == 3'b000) | (op[1:0] == 2'b11) | (op[4:3] == 2'b00);
      d.ctrl.mret        = sys & f.op21 & f3_zero;

      // Subtract for branches, compares and SUB
      d.alu.sub     = f.funct3[1] | f.funct3[0] | (op[3] & f.imm30) | op[4];
      d.alu.bool_op = f.funct3[1:0];
      d.alu.cmp_eq  = (f.funct3[2:1] == 2'b00);
      d.alu.cmp_sig = !((f.funct3[0] & f.funct3[1]) | (f.funct3[1] & f.funct3[2]));
      d.alu.rd_sel  = {f.funct3[2], (f.funct3[2:1] == 2'b01), f3_zero};

      d.mem.is_signed = !f.funct3[2];
      d.mem.word      = d.state.mdu_op | f.funct3[1];
      d.mem.half      = f.funct3[0];
      d.mem.cmd       = op[3];

      d.csr.en         = csr_op & csr_valid;
      d.csr.addr       = {f.op26 & f.op20, !f.op26 | f.op21};
      d.csr.mstatus_en = csr_op & !f.op26 & !f.op22;
      d.csr.mie_en     = csr_op & !f.op26 & f.op22 & !f.op20;
      d.csr.mcause_en  = csr_op & f.op21 & !f.op20;
      d.csr.source     = f.funct3[1:0];
      d.csr.d_sel      = f.funct3[2];
      d.csr.imm_en     = sys & f.funct3[2];

      // Immediate format select
      // Bit 0 S or B, bit 1 I S B, bit 2 B, bit 3 upper opcode half
      d.misc.immdec_ctrl[0] = (op[3:0] == 4'b1000);
      d.misc.immdec_ctrl[1] = (op[1:0] == 2'b00) | (op[2:1] == 2'b00);
      d.misc.immdec_ctrl[2] = op[4] & !op[0];
      d.misc.immdec_ctrl[3] = op[4];

      // Shift enables for the immediate field groups
      // 30:25 always, 24:20 for I J U, 19:12 for J U, 11:7 for S B
      d.misc.immdec_en[3] = op[4] | op[3] | op[2] | !op[0];
      d.misc.immdec_en[2] = (op[4] & op[2]) | !op[3] | op[0];
      d.misc.immdec_en[1] = (op[2:1] == 2'b01) | (op[2] & op[0]) | d.csr.imm_en;
      d.misc.immdec_en[0] = !d.state.rd_op;

      // Operand b from rs2 for OP and BRANCH
      d.misc.op_b_source = op[3];
      d.misc.rd_csr_en   = csr_op;
      d.misc.rd_alu_en   = op_or_opimm & !d.state.mdu_op;

      return d;
   endfunction

   fields_t     wb_fields;
   dec_groups_t groups;

   always_comb begin
      wb_fields.opcode = i_wb_rdt[6:2];
      wb_fields.funct3 = i_wb_rdt[14:12];
      wb_fields.op20   = i_wb_rdt[20];
      wb_fields.op21   = i_wb_rdt[21];
      wb_fields.op22   = i_wb_rdt[22];
      wb_fields.op26   = i_wb_rdt[26];
      wb_fields.imm25  = i_wb_rdt[25];
      wb_fields.imm30  = i_wb_rdt[30];
   end

   generate
      if (PRE_REGISTER) begin : g_pre_reg
         fields_t fields_q;

         // Raw fields captured on load, decode runs after the register
         always_ff @(posedge clk or negedge i_arst_n) begin
            if (!i_arst_n) begin
               fields_q <= '0;
            end else if (i_wb_en) begin
               fields_q <= wb_fields;
            end
         end

         assign groups = decode(fields_q);
      end else begin : g_post_reg
         localparam fields_t ZERO_FIELDS = '0;

         // Decode ahead of the register, reset to the decode of a zero word
         always_ff @(posedge clk or negedge i_arst_n) begin
            if (!i_arst_n) begin
               groups <= decode(ZERO_FIELDS);
            end else if (i_wb_en) begin
               groups <= decode(wb_fields);
            end
         end
      end
   endgenerate

   assign o_state  = groups.state;
   assign o_bufreg = groups.bufreg;
   assign o_ctrl   = groups.ctrl;
   assign o_alu    = groups.alu;
   assign o_mem    = groups.mem;
   assign o_csr    = groups.csr;
   assign o_misc   = groups.misc;

   // The internally stored CSRs are selected by at most one enable
   a_csr_onehot: assert property (@(posedge clk) disable iff (!i_arst_n)
      $onehot0({o_csr.mstatus_en, o_csr.mie_en, o_csr.mcause_en}))
      else $error("rv_decoder: more than one internal CSR enable at %0t", $time);

endmodule

/* source/rv_immdec.sv */
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module rv_immdec
   import rv_decode_pkg::*;
(
   input  logic    clk,
   input  logic    i_arst_n,
   input  logic    i_wb_en,
   input  instr_t  i_wb_rdt,
   input  logic    i_cnt_en,
   input  immdec_t i_immdec_ctrl,
   input  immdec_t i_immdec_en,
   output logic    o_imm
);

   localparam int CNT_W = $clog2(`RV_XLEN);

   // Immediate field groups, LSB of each group shifts out first
   logic             imm31;
   logic [5:0]       imm30_25;
   logic [4:0]       imm24_20;
   logic [4:0]       imm11_7;
   logic [8:0]       imm19_12_20;
   logic             imm7;
   logic [CNT_W-1:0] bit_idx;

   logic fmt_sb;
   logic fmt_b;
   logic fmt_j;
   logic fmt_u;
   logic u_wait;
   logic lead_zero;
   logic shift;
   logic feed_30_25;
   logic feed_19_12;

   // Format from the decoder select bits
   assign fmt_sb = i_immdec_ctrl[0];
   assign fmt_b  = i_immdec_ctrl[0] & i_immdec_ctrl[2];
   assign fmt_j  = !i_immdec_ctrl[1] & i_immdec_ctrl[3];
   assign fmt_u  = !i_immdec_ctrl[1] & !i_immdec_ctrl[3];

   // U holds its groups until the twelve low zero bits have gone out
   assign u_wait    = fmt_u & (bit_idx < CNT_W'(`RV_IMM_U_LSB));
   // B and J immediates have a zero LSB
   assign lead_zero = u_wait | ((fmt_b | fmt_j) & (bit_idx == '0));
   assign shift     = i_cnt_en & !u_wait;

   // Bit 11 comes from bit 7 in B and from bit 20 in J, then 19:12 in J
   assign feed_30_25 = fmt_b ? imm7 : (fmt_j ? imm19_12_20[0] : imm31);
   // J pulls sign into 19:12, U pulls 24:20 in above bit 19
   assign feed_19_12 = i_immdec_ctrl[3] ? imm31 : imm24_20[0];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         imm31       <= 1'b0;
         imm30_25    <= '0;
         imm24_20    <= '0;
         imm11_7     <= '0;
         imm19_12_20 <= '0;
         imm7        <= 1'b0;
         bit_idx     <= '0;
      end else if (i_wb_en) begin
         imm31       <= i_wb_rdt[31];
         imm30_25    <= i_wb_rdt[30:25];
         imm24_20    <= i_wb_rdt[24:20];
         imm11_7     <= i_wb_rdt[11:7];
         imm19_12_20 <= {i_wb_rdt[19:12], i_wb_rdt[20]};
         imm7        <= i_wb_rdt[7];
         bit_idx     <= '0;
      end else if (i_cnt_en) begin
         bit_idx <= bit_idx + CNT_W'(1);
         if (shift) begin
            imm7 <= imm31;
            if (i_immdec_en[3]) begin
               imm30_25 <= {feed_30_25, imm30_25[5:1]};
            end
            if (i_immdec_en[2]) begin
               imm24_20 <= {imm30_25[0], imm24_20[4:1]};
            end
            if (i_immdec_en[1]) begin
               imm19_12_20 <= {feed_19_12, imm19_12_20[8:1]};
            end
            if (i_immdec_en[0]) begin
               imm11_7 <= {imm30_25[0], imm11_7[4:1]};
            end
         end
      end
   end

   // Output tap by format, sign fills in from the top of the chain
   always_comb begin
      if (lead_zero) begin
         o_imm = 1'b0;
      end else if (fmt_u) begin
         o_imm = imm19_12_20[1];
      end else if (fmt_sb) begin
         o_imm = imm11_7[0];
      end else begin
         o_imm = imm24_20[0];
      end
   end

   // Fetch and execute never overlap
   a_no_load_shift: assert property (@(posedge clk) disable iff (!i_arst_n)
      !(i_wb_en && i_cnt_en))
      else $error("rv_immdec: load and shift in the same cycle at %0t", $time);

endmodule

/* source/rv_decode_top.sv */
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module rv_decode_top
   import rv_decode_pkg::*;
#(
   parameter bit PRE_REGISTER = `RV_DEC_PRE_REGISTER
) (
   input  logic        clk,
   input  logic        i_arst_n,
   // New instruction strobe and word
   input  logic        i_wb_en,
   input  instr_t      i_wb_rdt,
   // Serial immediate shift
   input  logic        i_cnt_en,
   output dec_state_t  o_state,
   output dec_bufreg_t o_bufreg,
   output dec_ctrl_t   o_ctrl,
   output dec_alu_t    o_alu,
   output dec_mem_t    o_mem,
   output dec_csr_t    o_csr,
   output dec_misc_t   o_misc,
   output logic        o_imm
);

   rv_decoder #(
      .PRE_REGISTER (PRE_REGISTER)
   ) decoder_i (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_wb_en  (i_wb_en),
      .i_wb_rdt (i_wb_rdt),
      .o_state  (o_state),
      .o_bufreg (o_bufreg),
      .o_ctrl   (o_ctrl),
      .o_alu    (o_alu),
      .o_mem    (o_mem),
      .o_csr    (o_csr),
      .o_misc   (o_misc)
   );

   // Format select and group enables come from the decoded word
   rv_immdec immdec_i (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_wb_en       (i_wb_en),
      .i_wb_rdt      (i_wb_rdt),
      .i_cnt_en      (i_cnt_en),
      .i_immdec_ctrl (o_misc.immdec_ctrl),
      .i_immdec_en   (o_misc.immdec_en),
      .o_imm         (o_imm)
   );

endmodule

/* test/tb_rv_decode_model.svh */
`ifndef TB_RV_DECODE_MODEL_SVH
`define TB_RV_DECODE_MODEL_SVH

// Major opcodes, instruction bits 6:2
localparam logic [4:0] OPC_LOAD   = 5'b00000;
localparam logic [4:0] OPC_STORE  = 5'b01000;
localparam logic [4:0] OPC_BRANCH = 5'b11000;
localparam logic [4:0] OPC_JALR   = 5'b11001;
localparam logic [4:0] OPC_JAL    = 5'b11011;
localparam logic [4:0] OPC_OPIMM  = 5'b00100;
localparam logic [4:0] OPC_OP     = 5'b01100;
localparam logic [4:0] OPC_AUIPC  = 5'b00101;
localparam logic [4:0] OPC_LUI    = 5'b01101;
localparam logic [4:0] OPC_SYSTEM = 5'b11100;

// Bits of care are the ones that the instruction class defines
function automatic void expect_groups(input logic [31:0] w, output groups_t exp,
                                      output groups_t care);
   logic [4:0]  opc;
   logic [2:0]  f3;
   logic [11:0] csr;
   logic        is_alu;
   logic        is_branch;
   logic        is_jump;
   logic        is_mem;
   logic        is_mdu;
   logic        is_shift;
   logic        is_e;
   logic        csr_acc;

   opc       = w[6:2];
   f3        = w[14:12];
   csr       = w[31:20];
   is_alu    = (opc == OPC_OP) || (opc == OPC_OPIMM);
   is_branch = (opc == OPC_BRANCH);
   is_jump   = (opc == OPC_JAL) || (opc == OPC_JALR);
   is_mem    = (opc == OPC_LOAD) || (opc == OPC_STORE);
   is_mdu    = (opc == OPC_OP) && w[25];
   is_shift  = is_alu && !is_mdu && (f3[1:0] == 2'b01);
   is_e      = (w == 32'h00000073) || (w == 32'h00100073);
   csr_acc   = (opc == OPC_SYSTEM) && (f3 != 3'b000);
   exp  = '0;
   care = '1;
   care.misc.immdec_ctrl = '0;
   care.misc.immdec_en   = '0;

   // SRL and SRA shift right
   exp.state.sh_right     = (f3 == 3'b101);
   care.state.sh_right    = is_shift;
   // BNE, BGE and BGEU invert the compare
   exp.state.bne_or_bge   = (f3 == 3'b001) || (f3 == 3'b101) || (f3 == 3'b111);
   care.state.bne_or_bge  = is_branch;
   exp.state.branch_op    = is_branch || is_jump;
   exp.state.cond_branch  = is_branch;
   care.state.cond_branch = is_branch || is_jump;
   exp.state.mem_op       = is_mem;
   exp.state.rd_op        = !((opc == OPC_STORE) || is_branch);
   exp.state.shift_op     = is_alu && (f3[1:0] == 2'b01);
   exp.state.slt_op       = is_alu && (f3[2:1] == 2'b01);
   exp.state.mdu_op       = is_mdu;
   exp.state.mdu_opcode   = f3;
   care.state.mdu_opcode  = {3{is_mdu}};
   exp.state.e_op         = is_e;
   exp.state.ebreak       = (w == 32'h00100073);
   care.state.ebreak      = is_e;

   // Buffer register takes rs1 for JALR, memory and shifts
   exp.bufreg.rs1_en     = (opc == OPC_JALR) || is_mem || is_shift;
   care.bufreg.rs1_en    = is_branch || is_jump || is_mem || is_shift;
   exp.bufreg.imm_en     = is_branch || is_jump || is_mem;
   care.bufreg.imm_en    = is_branch || is_jump || is_mem || is_shift;
   exp.bufreg.clr_lsb    = is_branch || (opc == OPC_JAL);
   care.bufreg.clr_lsb   = is_branch || is_jump || is_mem;
   exp.bufreg.sh_signed  = (f3 == 3'b101) && w[30];
   care.bufreg.sh_signed = is_shift;

   exp.ctrl.jal_or_jalr = is_jump;
   exp.ctrl.utype       = (opc == OPC_LUI) || (opc == OPC_AUIPC);
   exp.ctrl.pc_rel      = (opc == OPC_JAL) || is_branch || (opc == OPC_AUIPC);
   care.ctrl.pc_rel     = is_branch || is_jump || exp.ctrl.utype;
   exp.ctrl.mret        = (w == 32'h30200073);

   // SUB only exists in OP with funct3 zero
   care.alu         = '0;
   care.alu.sub     = is_alu || is_branch;
   exp.alu.sub      = (f3[1:0] != 2'b00) || ((opc == OPC_OP) && f3 == 3'b000 && w[30]) ||
                      is_branch;
   care.alu.bool_op = {2{is_alu}};
   exp.alu.bool_op  = f3[1:0];
   // One-hot result select of add, slt or bool
   care.alu.rd_sel  = {3{is_alu && !is_mdu && (f3[1:0] != 2'b01)}};
   case (f3)
      3'b000:         exp.alu.rd_sel = 3'b001;
      3'b010, 3'b011: exp.alu.rd_sel = 3'b010;
      default:        exp.alu.rd_sel = 3'b100;
   endcase
   // Equality for BEQ and BNE, signed for BLT, BGE and SLT
   exp.alu.cmp_eq   = (f3 == 3'b000) || (f3 == 3'b001);
   care.alu.cmp_eq  = is_branch;
   exp.alu.cmp_sig  = (f3 == 3'b100) || (f3 == 3'b101) || (f3 == 3'b010);
   care.alu.cmp_sig = (is_branch && f3[2]) || (is_alu && !is_mdu && (f3[2:1] == 2'b01));

   care.mem           = is_mem ? 4'hf : 4'h0;
   exp.mem.is_signed  = !f3[2];
   exp.mem.word       = f3[1];
   exp.mem.half       = f3[0];
   exp.mem.cmd        = (opc == OPC_STORE);

   exp.csr.en         = csr_acc && (csr == 12'h305 || csr == 12'h340 ||
                                    csr == 12'h341 || csr == 12'h343);
   exp.csr.addr       = {csr == 12'h341 || csr == 12'h343, csr == 12'h305 || csr == 12'h343};
   care.csr.addr      = {2{exp.csr.en}};
   exp.csr.mstatus_en = csr_acc && (csr == 12'h300);
   exp.csr.mie_en     = csr_acc && (csr == 12'h304);
   exp.csr.mcause_en  = csr_acc && (csr == 12'h342);
   exp.csr.source     = f3[1:0];
   exp.csr.d_sel      = f3[2];
   exp.csr.imm_en     = f3[2];
   care.csr.source    = {2{csr_acc}};
   care.csr.d_sel     = csr_acc;
   care.csr.imm_en    = csr_acc;

   exp.misc.op_b_source  = (opc == OPC_OP) || is_branch;
   care.misc.op_b_source = is_alu || is_branch || (opc == OPC_LOAD);
   exp.misc.rd_csr_en    = csr_acc;
   exp.misc.rd_alu_en    = is_alu && !is_mdu;
endfunction

// Standard immediate by format, returns 0 for words without a checked immediate
function automatic logic expect_imm(input logic [31:0] w, output logic [31:0] imm);
   imm = '0;
   case (w[6:2])
      OPC_LOAD, OPC_OPIMM, OPC_JALR: imm = {{20{w[31]}}, w[31:20]};
      OPC_STORE:                     imm = {{20{w[31]}}, w[31:25], w[11:7]};
      OPC_BRANCH: imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      OPC_LUI, OPC_AUIPC:            imm = {w[31:12], 12'h000};
      OPC_JAL: imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default: return 1'b0;
   endcase
   return 1'b1;
endfunction

`endif

/* test/tb_rv_decode.sv */
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module tb_rv_decode
   import rv_decode_pkg::*;
();

   localparam int NUM_TESTS   = 200;
   localparam int HOLD_CYCLES = 3;
   localparam logic [11:0] CSR_NUMS [0:6] = '{12'h300, 12'h304, 12'h305, 12'h340,
                                              12'h341, 12'h342, 12'h343};

   typedef struct packed {
      dec_state_t  state;
      dec_bufreg_t bufreg;
      dec_ctrl_t   ctrl;
      dec_alu_t    alu;
      dec_mem_t    mem;
      dec_csr_t    csr;
      dec_misc_t   misc;
   } groups_t;

   logic        clk = 1'b0;
   logic        i_arst_n;
   logic        i_wb_en;
   instr_t      i_wb_rdt;
   logic        i_cnt_en;
   dec_state_t  o_state;
   dec_bufreg_t o_bufreg;
   dec_ctrl_t   o_ctrl;
   dec_alu_t    o_alu;
   dec_mem_t    o_mem;
   dec_csr_t    o_csr;
   dec_misc_t   o_misc;
   logic        o_imm;
   logic [31:0] rng_state;
   int          errors;
   int          checks;
   int          bad_tests;

   `include "tb_rv_decode_model.svh"

   rv_decode_top dut_i (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_wb_en  (i_wb_en),
      .i_wb_rdt (i_wb_rdt),
      .i_cnt_en (i_cnt_en),
      .o_state  (o_state),
      .o_bufreg (o_bufreg),
      .o_ctrl   (o_ctrl),
      .o_alu    (o_alu),
      .o_mem    (o_mem),
      .o_csr    (o_csr),
      .o_misc   (o_misc),
      .o_imm    (o_imm)
   );

   always #20 clk = ~clk;

   function logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Random legal word, register fields stay random
   function automatic logic [31:0] make_instr();
      logic [31:0] w;
      logic [31:0] pick;
      logic [2:0]  f3;
      int          sel;

      w    = next_rand();
      pick = next_rand();
      f3   = w[14:12];
      case (pick % 10)
         0: w[6:0] = 7'b0110111;
         1: w[6:0] = 7'b0010111;
         2: w[6:0] = 7'b1101111;
         3: begin
            w[14:12] = 3'b000;
            w[6:0]   = 7'b1100111;
         end
         4: begin
            // Branch funct3 010 and 011 are reserved
            if (f3[2:1] == 2'b01) begin
               w[13] = 1'b0;
            end
            w[6:0] = 7'b1100011;
         end
         5: begin
            if (f3 == 3'b011) begin
               w[12] = 1'b0;
            end else if (f3[2:1] == 2'b11) begin
               w[13] = 1'b0;
            end
            w[6:0] = 7'b0000011;
         end
         6: begin
            w[14] = 1'b0;
            if (f3[1:0] == 2'b11) begin
               w[12] = 1'b0;
            end
            w[6:0] = 7'b0100011;
         end
         7: begin
            // Shift amounts carry a fixed upper field
            if (f3 == 3'b001) begin
               w[31:25] = 7'b0000000;
            end else if (f3 == 3'b101) begin
               w[31:25] = {1'b0, pick[8], 5'b00000};
            end
            w[6:0] = 7'b0010011;
         end
         8: begin
            if (pick[5:4] == 2'b00) begin
               w[31:25] = 7'b0000001;
            end else if (pick[4] && (f3 == 3'b000 || f3 == 3'b101)) begin
               w[31:25] = 7'b0100000;
            end else begin
               w[31:25] = 7'b0000000;
            end
            w[6:0] = 7'b0110011;
         end
         default: begin
            sel      = int'(pick[31:16]) % 7;
            w[31:20] = CSR_NUMS[sel];
            w[14:12] = {pick[10], (pick[9:8] == 2'b00) ? 2'b01 : pick[9:8]};
            w[6:0]   = 7'b1110011;
            // mret, ecall, ebreak
            if (pick[14:12] == 3'd0) begin
               w = 32'h30200073;
            end else if (pick[14:12] == 3'd1) begin
               w = 32'h00000073;
            end else if (pick[14:12] == 3'd2) begin
               w = 32'h00100073;
            end
         end
      endcase
      return w;
   endfunction

   task automatic wait_edges(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
      end
   endtask

   task automatic check_group(input string name, input logic [15:0] got, input logic [15:0] exp,
                              input logic [15:0] care, input logic [31:0] w);
      checks++;
      assert (((got ^ exp) & care) == 16'h0000)
      else begin
         errors++;
         $display("ERROR %0t: %s of %h is %h, expected %h", $time, name, w, got & care,
                  exp & care);
      end
   endtask

   task automatic compare_groups(input groups_t exp, input groups_t care, input logic [31:0] w,
                                 input string phase);
      check_group({phase, " state"}, 16'(o_state), 16'(exp.state), 16'(care.state), w);
      check_group({phase, " bufreg"}, 16'(o_bufreg), 16'(exp.bufreg), 16'(care.bufreg), w);
      check_group({phase, " ctrl"}, 16'(o_ctrl), 16'(exp.ctrl), 16'(care.ctrl), w);
      check_group({phase, " alu"}, 16'(o_alu), 16'(exp.alu), 16'(care.alu), w);
      check_group({phase, " mem"}, 16'(o_mem), 16'(exp.mem), 16'(care.mem), w);
      check_group({phase, " csr"}, 16'(o_csr), 16'(exp.csr), 16'(care.csr), w);
      check_group({phase, " misc"}, 16'(o_misc), 16'(exp.misc), 16'(care.misc), w);
   endtask

   // Load, check the groups, shift out the immediate, then check hold
   task automatic run_test(input int idx);
      logic [31:0] w;
      logic [31:0] noise;
      logic [31:0] exp_imm;
      logic [31:0] got_imm;
      logic        has_imm;
      groups_t     exp;
      groups_t     care;
      int          errs_before;

      w           = make_instr();
      has_imm     = expect_imm(w, exp_imm);
      errs_before = errors;
      expect_groups(w, exp, care);
      @(posedge clk);
      i_wb_en  <= 1'b1;
      i_wb_rdt <= w[31:2];
      @(posedge clk);
      i_wb_en  <= 1'b0;
      i_cnt_en <= 1'b1;
      @(negedge clk);
      compare_groups(exp, care, w, "decode");
      got_imm[0] = o_imm;
      for (int k = 1; k < 32; k++) begin
         @(posedge clk);
         @(negedge clk);
         got_imm[k] = o_imm;
      end
      @(posedge clk);
      i_cnt_en <= 1'b0;
      if (has_imm) begin
         checks++;
         assert (got_imm == exp_imm)
         else begin
            errors++;
            $display("ERROR %0t: immediate of %h is %h, expected %h", $time, w, got_imm, exp_imm);
         end
      end
      for (int h = 0; h < HOLD_CYCLES; h++) begin
         noise = next_rand();
         @(posedge clk);
         i_wb_rdt <= noise[31:2];
         @(negedge clk);
         compare_groups(exp, care, w, "hold");
      end
      if (errors != errs_before) begin
         bad_tests++;
      end
      $display("test %0d opcode %b word %h: %s", idx, w[6:2], w,
               (errors == errs_before) ? "ok" : "mismatch");
   endtask

   initial begin
      rng_state = 32'd93338;
      errors    = 0;
      checks    = 0;
      bad_tests = 0;
      i_arst_n <= 1'b0;
      i_wb_en  <= 1'b0;
      i_wb_rdt <= '0;
      i_cnt_en <= 1'b0;
      wait_edges(5);
      i_arst_n <= 1'b1;
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end
      $display("%0d tests run, %0d with errors, %0d checks, %0d errors", NUM_TESTS, bad_tests,
               checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* rv_decode_top.f */
+incdir+source
+incdir+test
source/rv_decode_pkg.sv
source/rv_decoder.sv
source/rv_immdec.sv
source/rv_decode_top.sv
test/tb_rv_decode.sv

/* Makefile */
BIN := obj_dir/Vtb_rv_decode

.PHONY: all run check clean

all: check

$(BIN): rv_decode_top.f $(wildcard source/*.sv source/*.svh test/*.sv test/*.svh)
	verilator --binary --timing --assert --top-module tb_rv_decode -f rv_decode_top.f

sim.log: $(BIN)
	./$(BIN) > sim.log 2>&1 || true

run: sim.log
	@cat sim.log

check: sim.log
	@if grep -q "tests failed" sim.log; then echo "simulation reported errors"; exit 1; fi
	@grep -q "all tests passed" sim.log || { echo "simulation ended early"; exit 1; }
	@echo "simulation clean"

clean:
	rm -rf obj_dir sim.log
